// File: uart_core.f
+incdir+verilog
verilog/uart_pkg.sv
verilog/uart_baud_gen.sv
verilog/uart_fifo.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_core.sv
verification/uart_core_props.sv
verification/uart_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the UART core testbench with Verilator, run it and judge the log.
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f uart_core.f --top-module uart_core_tb \
    -Mdir "$BUILD_DIR" -o uart_core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/uart_core_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" "$LOG"; then
    echo "result: PASS"
    exit 0
fi
echo "result: FAIL"
exit 1

// File: verification/uart_core_tb.sv
// UART core testbench
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module uart_core_tb;

    localparam int CLK_PERIOD = 100;
    localparam int DATA_W = `UART_DATA_BITS;
    localparam int DEPTH = `UART_FIFO_DEPTH;
    localparam int BIT_CLKS = `UART_CLKS_PER_OVS * `UART_OVERSAMPLE;  // 64 clk per bit
    localparam int FRAME_CLKS = 11 * BIT_CLKS;
    localparam int WAIT_LIMIT = 8 * FRAME_CLKS;  // longest legal wait, with margin
    localparam int RANDOM_COUNT = 20;

    logic               clk;
    logic               reset;
    logic               tx_valid;
    uart_pkg::tx_word_t tx_word;
    logic               tx_ready;
    logic               serial_out;
    logic               serial_in;
    logic               rx_valid;
    uart_pkg::rx_word_t rx_word;
    logic               rx_ready;
    logic               loopback;   // 1: rx line follows tx line
    logic               drv_line;   // serial model output
    logic [31:0]        lcg_state;
    logic [DATA_W-1:0]  rand_bytes [RANDOM_COUNT];
    int                 check_count;
    int                 mismatch_count;
    int                 timeout_count;

    assign serial_in = loopback ? serial_out : drv_line;  // loopback mux

    uart_core uut (
        .clk        (clk),
        .reset      (reset),
        .i_tx_valid (tx_valid),
        .i_tx_word  (tx_word),
        .o_tx_ready (tx_ready),
        .o_serial   (serial_out),
        .i_serial   (serial_in),
        .o_rx_valid (rx_valid),
        .o_rx_word  (rx_word),
        .i_rx_ready (rx_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            mismatch_count++;
            $display("[FAIL] %0t ns: %s, expected %0h, got %0h", $time, what, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        timeout_count++;
        $display("timeout at %0t ns: waited too long for %s", $time, what);
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // parity bit that makes the count of ones even
    function automatic logic even_parity(input logic [DATA_W-1:0] data);
        int ones;
        ones = 0;
        for (int i = 0; i < DATA_W; i++) begin
            if (data[i]) begin
                ones++;
            end
        end
        return (ones % 2) == 1;
    endfunction

    task automatic send_byte(input logic [DATA_W-1:0] data);
        int waited;
        waited = 0;
        @(negedge clk);
        tx_valid = 1'b1;
        tx_word.data = data;
        while (!tx_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (tx_ready) begin
            @(negedge clk);  // accepted on the rising edge in between
        end else begin
            report_timeout("o_tx_ready");
        end
        tx_valid = 1'b0;
    endtask

    task automatic recv_word(output uart_pkg::rx_word_t word, output bit got);
        int waited;
        waited = 0;
        word = '0;
        got = 1'b0;
        @(negedge clk);
        while (!rx_valid && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (rx_valid) begin
            word = rx_word;
            got = 1'b1;
            rx_ready = 1'b1;  // pops on the next rising edge
            @(negedge clk);
            rx_ready = 1'b0;
        end else begin
            report_timeout("o_rx_valid");
        end
    endtask

    task automatic expect_word(input logic [DATA_W-1:0] data, input logic perr,
                               input logic ferr, input string tag);
        uart_pkg::rx_word_t word;
        bit                 got;
        recv_word(word, got);
        if (got) begin
            check_value(32'(word.data), 32'(data), {tag, " data"});
            check_value(32'(word.parity_err), 32'(perr), {tag, " parity_err"});
            check_value(32'(word.frame_err), 32'(ferr), {tag, " frame_err"});
        end
    endtask

    // transmitter done once the line has stayed high for two bit times
    task automatic wait_line_idle();
        int waited;
        int high_run;
        waited = 0;
        high_run = 0;
        while (high_run < 2 * BIT_CLKS && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
            if (serial_out) begin
                high_run++;
            end else begin
                high_run = 0;
            end
        end
        if (high_run < 2 * BIT_CLKS) begin
            report_timeout("an idle transmit line");
        end
    endtask

    task automatic drive_bit(input logic level);
        drv_line = level;
        repeat (BIT_CLKS) @(negedge clk);  // one full bit time
    endtask

    task automatic drive_frame(input logic [DATA_W-1:0] data, input logic par,
                               input logic stop);
        @(negedge clk);
        drive_bit(1'b0);  // start
        for (int i = 0; i < DATA_W; i++) begin
            drive_bit(data[i]);  // lsb first
        end
        drive_bit(par);
        drive_bit(stop);
        drive_bit(1'b1);  // idle gap
        drive_bit(1'b1);
    endtask

    task automatic test_reset_state();
        check_value(32'(serial_out), 32'd1, "o_serial after reset");
        check_value(32'(rx_valid), 32'd0, "o_rx_valid after reset");
        check_value(32'(tx_ready), 32'd1, "o_tx_ready after reset");
    endtask

    task automatic test_single_byte();
        loopback = 1'b1;
        send_byte(8'hA5);
        expect_word(8'hA5, 1'b0, 1'b0, "single byte");
    endtask

    task automatic test_backpressure();
        logic [DATA_W-1:0] sent [$];
        logic [DATA_W-1:0] data;
        int                attempts;
        wait_line_idle();
        attempts = 0;
        rx_ready = 1'b0;  // consumer holds off
        @(negedge clk);
        while (tx_ready && attempts < 4 * DEPTH) begin
            data = 8'h30 + 8'(attempts);
            tx_valid = 1'b1;
            tx_word.data = data;
            sent.push_back(data);
            @(negedge clk);
            attempts++;
        end
        tx_valid = 1'b0;
        if (tx_ready) begin
            report_timeout("o_tx_ready to drop under back-pressure");
        end
        // fifo entries plus the word already in the shift register
        check_value(32'(sent.size()), 32'(DEPTH + 1), "bytes accepted before full");
        foreach (sent[i]) begin
            expect_word(sent[i], 1'b0, 1'b0, $sformatf("back-pressure byte %0d", i));
        end
    endtask

    task automatic test_parity_error();
        loopback = 1'b0;
        drive_frame(8'h3C, !even_parity(8'h3C), 1'b1);
        expect_word(8'h3C, 1'b1, 1'b0, "bad parity frame");
        loopback = 1'b1;
    endtask

    task automatic test_frame_error();
        loopback = 1'b0;
        drive_frame(8'hC3, even_parity(8'hC3), 1'b0);
        expect_word(8'hC3, 1'b0, 1'b1, "low stop frame");
        loopback = 1'b1;
    endtask

    task automatic test_random_stream();
        wait_line_idle();
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            lcg_state = lcg_next(lcg_state);
            rand_bytes[i] = lcg_state[23:16];  // upper bits have the longer period
        end
        fork
            begin
                for (int i = 0; i < RANDOM_COUNT; i++) begin
                    send_byte(rand_bytes[i]);
                end
            end
            begin
                for (int k = 0; k < RANDOM_COUNT; k++) begin
                    expect_word(rand_bytes[k], 1'b0, 1'b0, $sformatf("random byte %0d", k));
                end
            end
        join
    endtask

    initial begin
        reset = 1'b1;
        tx_valid = 1'b0;
        tx_word = '0;
        rx_ready = 1'b0;
        loopback = 1'b1;
        drv_line = 1'b1;
        lcg_state = 32'd76294;
        check_count = 0;
        mismatch_count = 0;
        timeout_count = 0;
        repeat (8) @(negedge clk);
        reset = 1'b0;

        test_reset_state();
        test_single_byte();
        test_backpressure();
        test_parity_error();
        test_frame_error();
        test_random_stream();

        $display("summary: %0d checks, %0d mismatches, %0d timeouts",
                 check_count, mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/uart_core_props.sv
// UART core assertions
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module uart_core_props #(
    parameter bit TX_CHECKS = 1'b0,  // transmitter instance
    parameter bit RX_CHECKS = 1'b0,  // top level instance
    parameter int FRAME_W = `UART_DATA_BITS + 4
) (
    input logic               clk,
    input logic               reset,
    input logic               i_bit_tick,
    input logic               o_ready,     // transmitter idle
    input logic               o_serial,
    input logic [FRAME_W-1:0] shift_reg,
    input logic               o_rx_valid
);

    if (TX_CHECKS) begin : g_tx
        // idle transmitter keeps the line at mark level
        idle_line_high: assert property (@(posedge clk) disable iff (reset)
            o_ready |-> o_serial)
            else $error("tx line low while transmitter idle");

        // a busy register only moves on a bit tick, so no word got loaded
        no_load_when_busy: assert property (@(posedge clk) disable iff (reset)
            (!o_ready && !i_bit_tick) |=> $stable(shift_reg))
            else $error("tx shift register changed while busy without a bit tick");

        line_high_after_reset: assert property (@(posedge clk)
            reset |=> o_serial)
            else $error("tx line not high after reset");
    end

    if (RX_CHECKS) begin : g_rx
        rx_valid_low_in_reset: assert property (@(posedge clk)
            reset |=> !o_rx_valid)
            else $error("o_rx_valid high during reset");
    end

endmodule

bind uart_tx uart_core_props #(.TX_CHECKS(1'b1)) u_tx_props (
    .clk(clk), .reset(reset), .i_bit_tick(i_bit_tick),
    .o_ready(o_ready), .o_serial(o_serial), .shift_reg(shift_reg), .o_rx_valid(1'b0)
);

bind uart_core uart_core_props #(.RX_CHECKS(1'b1)) u_core_props (
    .clk(clk), .reset(reset), .i_bit_tick(1'b0),
    .o_ready(1'b1), .o_serial(1'b1), .shift_reg('0), .o_rx_valid(o_rx_valid)
);

`default_nettype wire

// File: verilog/uart_core.sv
// UART core top level
`timescale 1ns/1ps
`default_nettype none

module uart_core (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_tx_valid,  // writer side
    input  uart_pkg::tx_word_t i_tx_word,
    output logic               o_tx_ready,
    output logic               o_serial,    // tx line
    input  logic               i_serial,    // rx line
    output logic               o_rx_valid,  // consumer side
    output uart_pkg::rx_word_t o_rx_word,
    input  logic               i_rx_ready
);

    logic               ovs_tick;   // receiver sampling strobe
    logic               bit_tick;   // transmitter shift strobe
    logic               txf_valid;  // tx fifo head toward the transmitter
    uart_pkg::tx_word_t txf_word;
    logic               tx_ready;   // transmitter idle
    logic               rx_valid;   // receiver push strobe
    uart_pkg::rx_word_t rx_word;

    uart_baud_gen u_baud_gen (
        .clk        (clk),
        .reset      (reset),
        .o_ovs_tick (ovs_tick),
        .o_bit_tick (bit_tick)
    );

    uart_fifo #(
        .payload_t (uart_pkg::tx_word_t)
    ) u_tx_fifo (
        .clk     (clk),
        .reset   (reset),
        .i_valid (i_tx_valid),
        .i_data  (i_tx_word),
        .o_ready (o_tx_ready),
        .o_valid (txf_valid),
        .o_data  (txf_word),
        .i_ready (tx_ready)
    );

    uart_tx u_tx (
        .clk        (clk),
        .reset      (reset),
        .i_bit_tick (bit_tick),
        .i_valid    (txf_valid),
        .i_word     (txf_word),
        .o_ready    (tx_ready),
        .o_serial   (o_serial)
    );

    uart_rx u_rx (
        .clk        (clk),
        .reset      (reset),
        .i_ovs_tick (ovs_tick),
        .i_serial   (i_serial),
        .o_valid    (rx_valid),
        .o_word     (rx_word)
    );

    // the receiver does not wait, a full fifo drops the frame
    uart_fifo #(
        .payload_t (uart_pkg::rx_word_t)
    ) u_rx_fifo (
        .clk     (clk),
        .reset   (reset),
        .i_valid (rx_valid),
        .i_data  (rx_word),
        .o_ready (),
        .o_valid (o_rx_valid),
        .o_data  (o_rx_word),
        .i_ready (i_rx_ready)
    );

endmodule

`default_nettype wire

// File: verilog/uart_rx.sv
// UART oversampling receiver
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module uart_rx (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_ovs_tick,  // 16 per bit time
    input  logic               i_serial,    // asynchronous line
    output logic               o_valid,     // one cycle per received frame
    output uart_pkg::rx_word_t o_word
);

    localparam int DATA_W = `UART_DATA_BITS;
    localparam int OVS = `UART_OVERSAMPLE;
    localparam int OVS_W = (OVS > 1) ? $clog2(OVS) : 1;
    localparam int IDX_W = $clog2(DATA_W + 1);  // data bits plus the parity bit

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } state_t;

    state_t            state;
    logic [1:0]        sync_q;     // two flop synchronizer
    logic              line;       // synchronized line
    logic              line_prev;  // line at the previous ovs tick
    logic [OVS_W-1:0]  ovs_cnt;    // ovs ticks since the last sample point
    logic [IDX_W-1:0]  bit_idx;    // bits sampled after the start bit
    logic [DATA_W-1:0] data_sr;    // lsb first, shifts in from the top
    logic              par_acc;    // xor over data and parity bits

    assign line = sync_q[1];

    always_ff @(posedge clk) begin
        if (reset) begin
            sync_q <= 2'b11;  // line idles high
        end else begin
            sync_q <= {sync_q[0], i_serial};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_IDLE;
            line_prev <= 1'b1;
            ovs_cnt   <= '0;
            bit_idx   <= '0;
            par_acc   <= 1'b0;
            o_valid   <= 1'b0;
        end else begin
            o_valid <= 1'b0;  // push strobe default
            if (i_ovs_tick) begin
                line_prev <= line;
                case (state)
                    ST_IDLE: begin
                        if (line_prev && !line) begin  // falling edge seen
                            state   <= ST_START;
                            ovs_cnt <= '0;
                        end
                    end
                    ST_START: begin
                        if (line) begin
                            state <= ST_IDLE;  // glitch, back high before mid bit
                        end else if (ovs_cnt == OVS_W'(OVS / 2 - 1)) begin
                            state   <= ST_DATA;  // mid start bit confirmed
                            ovs_cnt <= '0;
                            bit_idx <= '0;
                            par_acc <= 1'b0;
                        end else begin
                            ovs_cnt <= ovs_cnt + 1'b1;
                        end
                    end
                    ST_DATA: begin
                        if (ovs_cnt == OVS_W'(OVS - 1)) begin  // one bit time later
                            ovs_cnt <= '0;
                            par_acc <= par_acc ^ line;
                            if (bit_idx == IDX_W'(DATA_W)) begin
                                state <= ST_STOP;  // that was the parity bit
                            end else begin
                                data_sr <= {line, data_sr[DATA_W-1:1]};
                                bit_idx <= bit_idx + 1'b1;
                            end
                        end else begin
                            ovs_cnt <= ovs_cnt + 1'b1;
                        end
                    end
                    ST_STOP: begin
                        if (ovs_cnt == OVS_W'(OVS - 1)) begin  // mid stop bit
                            state             <= ST_IDLE;
                            o_valid           <= 1'b1;
                            o_word.data       <= data_sr;
                            o_word.parity_err <= par_acc;  // odd total is an error
                            o_word.frame_err  <= !line;    // stop must be high
                        end else begin
                            ovs_cnt <= ovs_cnt + 1'b1;
                        end
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/uart_tx.sv
// UART transmitter
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module uart_tx (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_bit_tick,  // one pulse per bit time
    input  logic               i_valid,
    input  uart_pkg::tx_word_t i_word,
    output logic               o_ready,     // low while a frame is in flight
    output logic               o_serial     // idles high
);

    localparam int DATA_W = `UART_DATA_BITS;

    // guard bit on top of stop, parity, data and start
    localparam int FRAME_W = DATA_W + 4;

    // piso register, bit 0 goes out first and zeros fill from the top
    logic [FRAME_W-1:0] shift_reg;
    logic               busy;    // register still holds frame bits
    logic               load;    // word accepted this cycle
    logic               parity;  // even parity over the byte

    // an all zero register means every bit has been shifted out
    assign busy    = (shift_reg != '0);
    assign o_ready = !busy;
    assign load    = i_valid && o_ready;
    assign parity  = ^i_word.data;  // makes data plus parity even

    // The guard bit is high like the idle line. It reaches o_serial one bit
    // time after the stop bit, and the register empties on that same tick,
    // so busy covers the full stop bit and the line stays high afterwards.
    always_ff @(posedge clk) begin
        if (reset) begin
            shift_reg <= '0;    // empty, not busy
            o_serial  <= 1'b1;  // idle level
        end else if (load) begin
            shift_reg <= {1'b1, 1'b1, parity, i_word.data, 1'b0};  // guard, stop, par, data, start
        end else if (i_bit_tick && busy) begin
            shift_reg <= {1'b0, shift_reg[FRAME_W-1:1]};  // zero fill marks progress
            o_serial  <= shift_reg[0];                    // next bit onto the line
        end
    end

endmodule

`default_nettype wire

// File: verilog/uart_fifo.sv
// UART valid/ready FIFO
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module uart_fifo #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     i_valid,  // write side
    input  payload_t i_data,
    output logic     o_ready,
    output logic     o_valid,  // read side
    output payload_t o_data,
    input  logic     i_ready
);

    localparam int DEPTH = `UART_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];  // circular storage
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;        // occupied entries
    logic             push;
    logic             pop;

    // pointer advance with wrap at DEPTH, works for any depth
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign o_ready = (count != CNT_W'(DEPTH));  // low only when full
    assign o_valid = (count != '0);              // low only when empty
    assign o_data  = mem[rd_ptr];                // head entry
    assign push    = i_valid && o_ready;
    assign pop     = o_valid && i_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);  // slot freed at this edge
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // none, or both at once
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/uart_baud_gen.sv
// UART baud tick generator
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module uart_baud_gen (
    input  logic clk,
    input  logic reset,
    output logic o_ovs_tick,  // one clk wide, every CLKS_PER_OVS cycles
    output logic o_bit_tick   // one clk wide, coincides with every 16th ovs tick
);

    localparam int CLKS = `UART_CLKS_PER_OVS;
    localparam int OVS = `UART_OVERSAMPLE;
    localparam int CLK_W = (CLKS > 1) ? $clog2(CLKS) : 1;
    localparam int OVS_W = (OVS > 1) ? $clog2(OVS) : 1;

    logic [CLK_W-1:0] clk_cnt;  // clk cycles within one ovs period
    logic [OVS_W-1:0] ovs_cnt;  // ovs ticks within one bit period

    always_ff @(posedge clk) begin
        if (reset) begin
            clk_cnt    <= '0;
            ovs_cnt    <= '0;
            o_ovs_tick <= 1'b0;
            o_bit_tick <= 1'b0;
        end else begin
            o_ovs_tick <= 1'b0;  // strobes default low
            o_bit_tick <= 1'b0;
            if (clk_cnt == CLK_W'(CLKS - 1)) begin
                clk_cnt    <= '0;
                o_ovs_tick <= 1'b1;
                if (ovs_cnt == OVS_W'(OVS - 1)) begin
                    ovs_cnt    <= '0;
                    o_bit_tick <= 1'b1;  // last ovs tick of the bit
                end else begin
                    ovs_cnt <= ovs_cnt + 1'b1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/uart_pkg.sv
// UART payload types
`default_nettype none

`include "uart_defines.svh"

package uart_pkg;

    // byte handed to the transmitter
    typedef struct packed {
        logic [`UART_DATA_BITS-1:0] data;  // payload byte
    } tx_word_t;

    // received byte with its line status
    typedef struct packed {
        logic [`UART_DATA_BITS-1:0] data;  // payload byte, lsb was first on the line
        logic                       parity_err;  // odd count over data plus parity
        logic                       frame_err;   // stop bit sampled low
    } rx_word_t;

endpackage

`default_nettype wire

// File: verilog/uart_defines.svh
// UART configuration macros
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// clk cycles per oversampling tick, kept small for simulation
`define UART_CLKS_PER_OVS 4

// oversampling ticks per bit time
`define UART_OVERSAMPLE 16

// data bits per frame, sent lsb first
`define UART_DATA_BITS 8

// entries in each of the tx and rx fifos
`define UART_FIFO_DEPTH 4

`endif
